// ==== build.f ====
+incdir+common
common/txdp_word_pkg.sv
common/txdp_cfg_pkg.sv
rtl/txdp_word_marker.sv
txdp_fifo/txdp_fifo_store.sv
txdp_fifo/txdp_fifo_unload.sv
rtl/txdp_pulse_stretch.sv
rtl/txdp_top.sv
test/txdp_clock_gen.sv
test/txdp_tb.sv

// ==== common/txdp_cfg_pkg.sv ====
`include "txdp_params.svh"

package txdp_cfg_pkg;

  // ---------------------------------------------------------------------------
  // Static configuration
  // ---------------------------------------------------------------------------

  typedef logic [`TXDP_STR_W-1:0] stages_t;

  // Held static while traffic runs
  typedef struct packed {
    logic                 wm_en;
    logic                 double_write;
    logic                 stop_write;
    logic                 stop_read;
    // Partially full at or above this level
    txdp_word_pkg::level_t pfull_thr;
    // Partially empty at or below this level, also the ready threshold
    txdp_word_pkg::level_t pempty_thr;
    stages_t              stretch_stages;
  } txdp_cfg_t;

  // ---------------------------------------------------------------------------
  // Unloader FSM
  // ---------------------------------------------------------------------------

  // Names the beat sent in the previous cycle
  typedef enum logic [1:0] {
    UNLOAD_IDLE,
    UNLOAD_LOW,
    UNLOAD_HIGH
  } unload_state_t;

endpackage

// ==== common/txdp_params.svh ====
`ifndef TXDP_PARAMS_SVH
`define TXDP_PARAMS_SVH

// ---------------------------------------------------------------------------
// Data widths of the transmit path
// ---------------------------------------------------------------------------

// Transmit word as it arrives from the core side
`define TXDP_IN_W 78

// Stored FIFO word, two output halves with marker bits
`define TXDP_WORD_W 80

// One output half toward the lane
`define TXDP_OUT_W 40

// ---------------------------------------------------------------------------
// FIFO geometry and flag stretching
// ---------------------------------------------------------------------------

// Depth is 2 to this power
`define TXDP_ADDR_W 4

`define TXDP_STR_W 3

`endif

// ==== common/txdp_word_pkg.sv ====
`include "txdp_params.svh"

package txdp_word_pkg;

  // ---------------------------------------------------------------------------
  // Data words
  // ---------------------------------------------------------------------------

  typedef logic [`TXDP_IN_W-1:0] in_word_t;

  // Bit 79 and bit 39 carry the word markers when enabled
  typedef logic [`TXDP_WORD_W-1:0] fifo_word_t;

  typedef logic [`TXDP_OUT_W-1:0] out_word_t;

  // Occupancy 0 to 16, one bit wider than the address
  typedef logic [`TXDP_ADDR_W:0] level_t;

  // ---------------------------------------------------------------------------
  // FIFO status
  // ---------------------------------------------------------------------------

  typedef struct packed {
    logic   full;
    logic   empty;
    logic   pfull;
    logic   pempty;
    logic   ready;
    level_t count;
  } fifo_status_t;

endpackage

// ==== rtl/txdp_pulse_stretch.sv ====
`include "txdp_params.svh"

module txdp_pulse_stretch #(
  parameter bit RESET_VAL = 1'b0
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  txdp_cfg_pkg::stages_t num_stages,
  input  logic                  flag_in,
  output logic                  flag_out
);

  localparam int HIST_N = 1 << `TXDP_STR_W;

  // Newest sample at index 0
  logic [HIST_N-1:0] hist;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      hist <= {HIST_N{RESET_VAL}};
    end else begin
      hist <= {hist[HIST_N-2:0], flag_in};
    end
  end

  // OR over the last num_stages plus 1 samples
  always_comb begin
    flag_out = 1'b0;
    for (int i = 0; i < HIST_N; i++) begin
      if (i <= int'(num_stages)) begin
        flag_out = flag_out | hist[i];
      end
    end
  end

endmodule

// ==== rtl/txdp_top.sv ====
module txdp_top (
  input  logic                     clk,
  input  logic                     arst_n,
  input  txdp_word_pkg::in_word_t   data_in,
  input  logic                     data_write,
  input  logic                     lpbk_en,
  input  txdp_word_pkg::fifo_word_t lpbk_data,
  input  txdp_cfg_pkg::txdp_cfg_t   cfg,
  input  logic                     data_read,
  output txdp_word_pkg::out_word_t  dout,
  output logic                     dout_valid,
  output logic                     full_flag,
  output logic                     empty_flag,
  output logic                     pfull,
  output logic                     pempty,
  output logic                     fifo_ready
);

  txdp_word_pkg::fifo_word_t   wr_word;
  logic                        wr_strobe;
  txdp_word_pkg::fifo_word_t   rd_word;
  txdp_word_pkg::fifo_status_t status;
  logic                        pop;

  // ---------------------------------------------------------------------------
  // Producer, buffer and consumer
  // ---------------------------------------------------------------------------

  txdp_word_marker u_marker (
    .clk        (clk),
    .arst_n     (arst_n),
    .data_in    (data_in),
    .data_write (data_write),
    .lpbk_en    (lpbk_en),
    .lpbk_data  (lpbk_data),
    .cfg        (cfg),
    .wr_word    (wr_word),
    .wr_strobe  (wr_strobe)
  );

  txdp_fifo_store u_store (
    .clk       (clk),
    .arst_n    (arst_n),
    .wr_word   (wr_word),
    .wr_strobe (wr_strobe),
    .pop       (pop),
    .cfg       (cfg),
    .rd_word   (rd_word),
    .status    (status)
  );

  txdp_fifo_unload u_unload (
    .clk        (clk),
    .arst_n     (arst_n),
    .data_read  (data_read),
    .cfg        (cfg),
    .status     (status),
    .rd_word    (rd_word),
    .pop        (pop),
    .dout       (dout),
    .dout_valid (dout_valid)
  );

  // ---------------------------------------------------------------------------
  // Stretched flags for slow sampling
  // ---------------------------------------------------------------------------

  txdp_pulse_stretch #(
    .RESET_VAL (1'b0)
  ) u_full_stretch (
    .clk        (clk),
    .arst_n     (arst_n),
    .num_stages (cfg.stretch_stages),
    .flag_in    (status.full),
    .flag_out   (full_flag)
  );

  // Empty after reset
  txdp_pulse_stretch #(
    .RESET_VAL (1'b1)
  ) u_empty_stretch (
    .clk        (clk),
    .arst_n     (arst_n),
    .num_stages (cfg.stretch_stages),
    .flag_in    (status.empty),
    .flag_out   (empty_flag)
  );

  assign pfull      = status.pfull;
  assign pempty     = status.pempty;
  assign fifo_ready = status.ready;

endmodule

// ==== rtl/txdp_word_marker.sv ====
`include "txdp_params.svh"

module txdp_word_marker (
  input  logic                     clk,
  input  logic                     arst_n,
  input  txdp_word_pkg::in_word_t   data_in,
  input  logic                     data_write,
  input  logic                     lpbk_en,
  input  txdp_word_pkg::fifo_word_t lpbk_data,
  input  txdp_cfg_pkg::txdp_cfg_t   cfg,
  output txdp_word_pkg::fifo_word_t wr_word,
  output logic                     wr_strobe
);

  localparam int HALF_W = `TXDP_OUT_W;
  localparam int PAD_W  = `TXDP_WORD_W - `TXDP_IN_W;

  txdp_word_pkg::fifo_word_t word_c;
  logic                      strobe_c;

  // Input select, loopback wins over marker insertion
  always_comb begin
    if (lpbk_en) begin
      word_c = lpbk_data;
    end else if (cfg.wm_en) begin
      // Marker 1 on the high half, 0 on the low half
      word_c = {1'b1, data_in[`TXDP_IN_W-1:HALF_W-1], 1'b0, data_in[HALF_W-2:0]};
    end else begin
      word_c = {{PAD_W{1'b0}}, data_in};
    end
  end

  assign strobe_c = data_write & ~cfg.stop_write;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_strobe <= 1'b0;
    end else begin
      wr_strobe <= strobe_c;
    end
  end

  always_ff @(posedge clk) begin
    wr_word <= word_c;
  end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds and runs the transmit data-path testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f build.f --top-module txdp_tb -o sim_txdp

./obj_dir/sim_txdp | tee sim.log

if grep -qx "Finished with no errors" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi

// ==== test/txdp_clock_gen.sv ====
module txdp_clock_gen (
  output logic clk,
  output logic arst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_NS      = 10;
  localparam int RESET_CYCLES = 3;

  initial begin
    clk = 1'b0;
    forever #(HALF_NS) clk = ~clk;
  end

  // Released just after the third rising edge
  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    arst_n <= 1'b1;
  end

endmodule

// ==== test/txdp_tb.sv ====
`include "txdp_params.svh"

module txdp_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_NS = 20;
  localparam int DEPTH  = 1 << `TXDP_ADDR_W;
  localparam int HALF_W = `TXDP_OUT_W;

  logic                      clk;
  logic                      arst_n;
  txdp_word_pkg::in_word_t   data_in;
  logic                      data_write;
  logic                      lpbk_en;
  txdp_word_pkg::fifo_word_t lpbk_data;
  txdp_cfg_pkg::txdp_cfg_t   cfg;
  logic                      data_read;
  txdp_word_pkg::out_word_t  dout;
  logic                      dout_valid;
  logic                      full_flag;
  logic                      empty_flag;
  logic                      pfull;
  logic                      pempty;
  logic                      fifo_ready;

  // Expected words in FIFO order, oldest first
  txdp_word_pkg::fifo_word_t model_q[$];
  txdp_cfg_pkg::txdp_cfg_t   cur_cfg;
  string                     lines[$];
  string                     test_name;
  logic [31:0]               lfsr_state;
  int                        errors;
  int                        checks;
  int                        beats;
  int                        budget_ns;
  bit                        half_hi;
  bit                        mid_cycle;

  txdp_clock_gen u_clock_gen (
    .clk    (clk),
    .arst_n (arst_n)
  );

  txdp_top DUT (
    .clk        (clk),
    .arst_n     (arst_n),
    .data_in    (data_in),
    .data_write (data_write),
    .lpbk_en    (lpbk_en),
    .lpbk_data  (lpbk_data),
    .cfg        (cfg),
    .data_read  (data_read),
    .dout       (dout),
    .dout_valid (dout_valid),
    .full_flag  (full_flag),
    .empty_flag (empty_flag),
    .pfull      (pfull),
    .pempty     (pempty),
    .fifo_ready (fifo_ready)
  );

  // ---------------------------------------------------------------------------
  // Reference model
  // ---------------------------------------------------------------------------

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic txdp_word_pkg::in_word_t random_word();
    txdp_word_pkg::in_word_t w;
    for (int i = 0; i < `TXDP_IN_W; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w[i] = lfsr_state[0];
    end
    return w;
  endfunction

  function automatic txdp_word_pkg::fifo_word_t expected_word(
    input txdp_word_pkg::in_word_t d, input logic wm, input logic le,
    input txdp_word_pkg::fifo_word_t ld);
    txdp_word_pkg::fifo_word_t w;
    w = '0;
    if (le) begin
      w = ld;
    end else if (wm) begin
      // Markers at 79 and 39, the input splits around bit 39
      w[79]    = 1'b1;
      w[78:40] = d[77:39];
      w[38:0]  = d[38:0];
    end else begin
      w[77:0] = d;
    end
    return w;
  endfunction

  function automatic int line_cycles(input string line);
    string cmd;
    int    n;
    int    cnt;
    cnt = 0;
    n   = 0;
    if ($sscanf(line, "%s %d", cmd, n) >= 1) begin
      if (cmd == "CFG") begin
        cnt = 1;
      end else if (cmd == "WR" || cmd == "IDLE") begin
        cnt = n;
      end else if (cmd == "RD") begin
        cnt = n + 2;
      end
    end
    return cnt;
  endfunction

  // ---------------------------------------------------------------------------
  // Stimulus
  // ---------------------------------------------------------------------------

  task automatic drive_cycle(input logic wr, input logic rd,
                             input txdp_word_pkg::in_word_t d, input logic le,
                             input txdp_word_pkg::fifo_word_t ld);
    @(posedge clk);
    cfg        <= cur_cfg;
    data_write <= wr;
    // Reads stay requested while stopped, only stop_read holds the words
    data_read  <= rd | cur_cfg.stop_read;
    data_in    <= d;
    lpbk_en    <= le;
    lpbk_data  <= ld;
    mid_cycle  = 1'b0;
  endtask

  // Just past the falling edge, after the monitor has run
  task automatic settle_mid_cycle();
    if (!mid_cycle) begin
      @(negedge clk);
      #1;
      mid_cycle = 1'b1;
    end
  endtask

  task automatic apply_cfg(input string line);
    string cmd;
    int    wm, dw, sw, sr, pf, pe, st;
    if ($sscanf(line, "%s %h %h %h %h %h %h %h", cmd, wm, dw, sw, sr, pf, pe, st) < 8) begin
      errors++;
      $display("Malformed configuration in %s", test_name);
    end
    cur_cfg.wm_en          = wm[0];
    cur_cfg.double_write   = dw[0];
    cur_cfg.stop_write     = sw[0];
    cur_cfg.stop_read      = sr[0];
    cur_cfg.pfull_thr      = txdp_word_pkg::level_t'(pf);
    cur_cfg.pempty_thr     = txdp_word_pkg::level_t'(pe);
    cur_cfg.stretch_stages = txdp_cfg_pkg::stages_t'(st);
    drive_cycle(1'b0, 1'b0, '0, 1'b0, '0);
  endtask

  task automatic issue_writes(input string line);
    string                     cmd;
    string                     dstr;
    int                        cycles;
    int                        le;
    txdp_word_pkg::fifo_word_t ld;
    txdp_word_pkg::in_word_t   d;
    d = '0;
    if ($sscanf(line, "%s %d %s %h %h", cmd, cycles, dstr, le, ld) < 5) begin
      errors++;
      $display("Malformed write command in %s", test_name);
    end else if (dstr != "RAND") begin
      void'($sscanf(dstr, "%h", d));
    end
    repeat (cycles) begin
      if (dstr == "RAND") begin
        d = random_word();
      end
      drive_cycle(1'b1, 1'b0, d, le[0], ld);
      // Words beyond the depth are lost
      if (!cur_cfg.stop_write && model_q.size() < DEPTH) begin
        model_q.push_back(expected_word(d, cur_cfg.wm_en, le[0], ld));
      end
    end
  endtask

  task automatic issue_reads(input string line);
    string cmd;
    int    cycles;
    int    want;
    int    start;
    void'($sscanf(line, "%s %d %d", cmd, cycles, want));
    start = beats;
    repeat (cycles) drive_cycle(1'b0, 1'b1, '0, 1'b0, '0);
    drive_cycle(1'b0, 1'b0, '0, 1'b0, '0);
    // Room for a trailing high half
    @(posedge clk);
    settle_mid_cycle();
    checks++;
    assert (beats - start == want) else begin
      errors++;
      $display("** Error: %s output beats expected %0d actual %0d",
               test_name, want, beats - start);
    end
  endtask

  task automatic compare_flags(input string line);
    string      cmd;
    int         f0, f1, f2, f3, f4;
    logic [4:0] want;
    logic [4:0] got;
    void'($sscanf(line, "%s %h %h %h %h %h", cmd, f0, f1, f2, f3, f4));
    want = {f0[0], f1[0], f2[0], f3[0], f4[0]};
    settle_mid_cycle();
    got = {full_flag, empty_flag, pfull, pempty, fifo_ready};
    checks++;
    assert (got === want) else begin
      errors++;
      $display("** Error: %s full/empty/pfull/pempty/ready expected %b actual %b",
               test_name, want, got);
    end
  endtask

  task automatic dispatch_line(input string line, input int num);
    string cmd;
    int    n;
    cmd = "";
    n   = $sscanf(line, "%s", cmd);
    if (n >= 1 && cmd.substr(0, 0) != "#") begin
      test_name = $sformatf("%s line %0d", cmd, num);
      if (cmd == "CFG") begin
        apply_cfg(line);
      end else if (cmd == "WR") begin
        issue_writes(line);
      end else if (cmd == "RD") begin
        issue_reads(line);
      end else if (cmd == "IDLE") begin
        void'($sscanf(line, "%s %d", cmd, n));
        repeat (n) drive_cycle(1'b0, 1'b0, '0, 1'b0, '0);
      end else if (cmd == "FLAG") begin
        compare_flags(line);
      end else begin
        errors++;
        $display("Unknown trace command %s on line %0d", cmd, num);
      end
    end
  endtask

  // ---------------------------------------------------------------------------
  // Output monitor
  // ---------------------------------------------------------------------------

  always @(negedge clk) begin
    txdp_word_pkg::out_word_t want;
    if (arst_n && dout_valid) begin
      beats++;
      checks++;
      assert (model_q.size() > 0) else begin
        errors++;
        $display("Output beat in %s with no word left to send", test_name);
      end
      if (model_q.size() > 0) begin
        want = half_hi ? model_q[0][2*HALF_W-1:HALF_W] : model_q[0][HALF_W-1:0];
        assert (dout === want) else begin
          errors++;
          $display("** Error: %s dout expected %h actual %h", test_name, want, dout);
        end
        if (cfg.double_write && !half_hi) begin
          half_hi = 1'b1;
        end else begin
          half_hi = 1'b0;
          void'(model_q.pop_front());
        end
      end
    end
  end

  // Budget comes from the trace length
  initial begin
    wait (budget_ns > 0);
    #(budget_ns);
    $display("Timeout, the trace did not complete within %0d ns", budget_ns);
    $display("Finished with errors");
    $finish;
  end

  // ---------------------------------------------------------------------------
  // Main sequence
  // ---------------------------------------------------------------------------

  initial begin
    int    fd;
    int    total;
    string line;
    data_in    = '0;
    data_write = 1'b0;
    lpbk_en    = 1'b0;
    lpbk_data  = '0;
    cfg        = '0;
    data_read  = 1'b0;
    cur_cfg    = '0;
    lfsr_state = 32'h99a82787;
    total      = 0;
    fd = $fopen("test/txdp_trace.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the trace file test/txdp_trace.txt");
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) > 0) begin
          lines.push_back(line);
        end
      end
      $fclose(fd);
    end
    foreach (lines[i]) total += line_cycles(lines[i]);
    budget_ns = (total + 60) * CLK_NS;
    // Reset levels, sampled while the reset is still held
    @(posedge clk);
    @(negedge clk);
    test_name = "reset";
    checks++;
    assert ({full_flag, empty_flag, dout_valid, fifo_ready} === 4'b0100) else begin
      errors++;
      $display("** Error: %s full/empty/valid/ready expected %b actual %b",
               test_name, 4'b0100, {full_flag, empty_flag, dout_valid, fifo_ready});
    end
    wait (arst_n === 1'b1);
    foreach (lines[i]) dispatch_line(lines[i], i + 1);
    repeat (2) @(posedge clk);
    checks++;
    assert (model_q.size() == 0) else begin
      errors++;
      $display("%0d written words never reached the output", model_q.size());
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== test/txdp_trace.txt ====
# Hex fields. CFG wm_en double_write stop_write stop_read pfull_thr pempty_thr stages
# WR cycles data|RAND lpbk_en lpbk_data, RD cycles halves, IDLE cycles, FLAG full empty pfull pempty ready
CFG 1 0 0 0 6 3 2
IDLE 2
FLAG 0 1 0 1 0
WR 1 3fffffffffffffffffff 0 0
WR 2 RAND 0 0
IDLE 4
FLAG 0 0 0 1 0
RD 4 0
WR 1 RAND 0 0
IDLE 3
FLAG 0 0 0 0 1
RD 6 4
FLAG 0 1 0 1 1
CFG 0 0 0 0 6 3 2
WR 2 3fffffffffffffffffff 0 0
RD 5 2
CFG 1 1 0 0 6 3 2
WR 3 RAND 0 0
RD 9 6
WR 2 RAND 1 0123456789abcdef0123
RD 7 4
CFG 1 0 0 1 5 2 2
WR 2 RAND 0 0
IDLE 4
FLAG 0 0 0 1 1
WR 3 RAND 0 0
IDLE 4
FLAG 0 0 1 0 1
WR 15 RAND 0 0
IDLE 4
FLAG 1 0 1 0 1
CFG 1 0 0 0 5 2 2
RD 1 1
FLAG 1 0 1 0 1
IDLE 1
FLAG 1 0 1 0 1
IDLE 1
FLAG 0 0 1 0 1
CFG 1 0 1 0 5 2 2
WR 3 RAND 0 0
IDLE 4
FLAG 0 0 1 0 1
CFG 1 0 0 0 5 2 2
RD 18 15
FLAG 0 1 0 1 1

// ==== txdp_fifo/txdp_fifo_store.sv ====
`include "txdp_params.svh"

module txdp_fifo_store (
  input  logic                       clk,
  input  logic                       arst_n,
  input  txdp_word_pkg::fifo_word_t   wr_word,
  input  logic                       wr_strobe,
  input  logic                       pop,
  input  txdp_cfg_pkg::txdp_cfg_t     cfg,
  output txdp_word_pkg::fifo_word_t   rd_word,
  output txdp_word_pkg::fifo_status_t status
);

  localparam int DEPTH = 1 << `TXDP_ADDR_W;

  typedef logic [`TXDP_ADDR_W-1:0] ptr_t;

  txdp_word_pkg::fifo_word_t mem [DEPTH];

  ptr_t                  wr_ptr;
  ptr_t                  rd_ptr;
  txdp_word_pkg::level_t count;
  txdp_word_pkg::level_t count_next;
  logic                  push;
  logic                  pull;
  logic                  full;
  logic                  empty;
  logic                  ready_q;

  // ---------------------------------------------------------------------------
  // Occupancy
  // ---------------------------------------------------------------------------

  assign full  = (count == txdp_word_pkg::level_t'(DEPTH));
  assign empty = (count == '0);

  // A strobe while full is lost
  assign push = wr_strobe & ~full;
  assign pull = pop & ~empty;

  always_comb begin
    case ({push, pull})
      2'b10:   count_next = count + txdp_word_pkg::level_t'(1);
      2'b01:   count_next = count - txdp_word_pkg::level_t'(1);
      default: count_next = count;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pull) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count_next;
    end
  end

  // ---------------------------------------------------------------------------
  // Storage
  // ---------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= wr_word;
    end
  end

  // Head word, valid while not empty
  assign rd_word = mem[rd_ptr];

  // ---------------------------------------------------------------------------
  // Ready and flags
  // ---------------------------------------------------------------------------

  // Sticky, rises on the same edge the count crosses the threshold
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ready_q <= 1'b0;
    end else if (count_next > cfg.pempty_thr) begin
      ready_q <= 1'b1;
    end
  end

  always_comb begin
    status.full   = full;
    status.empty  = empty;
    status.pfull  = (count >= cfg.pfull_thr);
    status.pempty = (count <= cfg.pempty_thr);
    status.ready  = ready_q;
    status.count  = count;
  end

endmodule

// ==== txdp_fifo/txdp_fifo_unload.sv ====
`include "txdp_params.svh"

module txdp_fifo_unload (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       data_read,
  input  txdp_cfg_pkg::txdp_cfg_t     cfg,
  input  txdp_word_pkg::fifo_status_t status,
  input  txdp_word_pkg::fifo_word_t   rd_word,
  output logic                       pop,
  output txdp_word_pkg::out_word_t    dout,
  output logic                       dout_valid
);

  localparam int HALF_W = `TXDP_OUT_W;

  txdp_cfg_pkg::unload_state_t state;
  txdp_cfg_pkg::unload_state_t state_next;
  txdp_word_pkg::out_word_t    hi_hold;
  logic                        can_pop;
  logic                        send_high;

  // ---------------------------------------------------------------------------
  // Pop decision
  // ---------------------------------------------------------------------------

  assign can_pop = data_read & ~cfg.stop_read & status.ready & ~status.empty;

  // High half owes a beat right after a low half
  assign send_high = cfg.double_write && (state == txdp_cfg_pkg::UNLOAD_LOW);

  assign pop = can_pop & ~send_high;

  always_comb begin
    if (pop) begin
      state_next = txdp_cfg_pkg::UNLOAD_LOW;
    end else if (send_high) begin
      state_next = txdp_cfg_pkg::UNLOAD_HIGH;
    end else begin
      state_next = txdp_cfg_pkg::UNLOAD_IDLE;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= txdp_cfg_pkg::UNLOAD_IDLE;
      dout_valid <= 1'b0;
    end else begin
      state      <= state_next;
      dout_valid <= pop | send_high;
    end
  end

  // ---------------------------------------------------------------------------
  // Output halves
  // ---------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (pop) begin
      dout    <= rd_word[HALF_W-1:0];
      hi_hold <= rd_word[2*HALF_W-1:HALF_W];
    end else if (send_high) begin
      dout <= hi_hold;
    end
  end

endmodule
